//--- sim/rv_core_tb.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_core_tb;

  localparam int op_add = 0, op_sub = 1, op_sll = 2, op_slt = 3, op_sltu = 4;
  localparam int op_xor = 5, op_srl = 6, op_sra = 7, op_or = 8, op_and = 9;
  localparam logic [31:0] res_adr = 32'h100; // Byte address of every result store
  localparam logic [31:0] mem_adr = 32'h200;
  localparam logic [6:0] opc_imm = 7'b0010011;

  logic clk_i, reset_ni;
  logic wb_i_ack_i, wb_i_cyc_o, wb_i_stb_o;
  logic [`RV_XLEN-1:0] wb_i_data_i;
  logic [`RV_AW-1:0] wb_i_adr_o;
  logic wb_d_ack_i, wb_d_we_o, wb_d_cyc_o, wb_d_stb_o;
  logic [`RV_XLEN-1:0] wb_d_data_i, wb_d_dat_o;
  logic [`RV_AW-1:0] wb_d_adr_o;

  logic [31:0] imem [0:1023];
  logic [31:0] dmem [0:255];
  logic [31:0] rng_state = 32'd8;
  int unsigned pc_w;
  logic i_busy = 1'b0;
  logic d_busy = 1'b0;
  int i_wait, d_wait;
  string exp_name_q[$];
  logic [31:0] exp_adr_q[$], exp_dat_q[$], got_adr_q[$], got_dat_q[$];

  rv_core rv_core_inst (
    .clk_i, .reset_ni,
    .wb_i_ack_i, .wb_i_data_i, .wb_i_adr_o, .wb_i_cyc_o, .wb_i_stb_o,
    .wb_d_ack_i, .wb_d_data_i, .wb_d_adr_o, .wb_d_dat_o, .wb_d_we_o, .wb_d_cyc_o, .wb_d_stb_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] ref_alu(input int op, input logic [31:0] a, b);
    case (op)
      op_add: return a + b;
      op_sub: return a - b;
      op_sll: return a << b[4:0];
      op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sltu: return (a < b) ? 32'd1 : 32'd0;
      op_xor: return a ^ b;
      op_srl: return a >> b[4:0];
      op_sra: return $signed(a) >>> b[4:0];
      op_or: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input int k, input logic [31:0] a, b);
    case (k)
      0: return a == b;
      1: return a != b;
      2: return $signed(a) < $signed(b);
      3: return $signed(a) >= $signed(b);
      4: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [2:0] op_f3(input int op);
    case (op)
      op_add, op_sub: return 3'd0;
      op_sll: return 3'd1;
      op_slt: return 3'd2;
      op_sltu: return 3'd3;
      op_xor: return 3'd4;
      op_srl, op_sra: return 3'd5;
      op_or: return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  function automatic logic op_alt(input int op);
    return op == op_sub || op == op_sra; // funct7 bit 5
  endfunction

  function automatic string op_name(input int op);
    case (op)
      op_add: return "ADD";
      op_sub: return "SUB";
      op_sll: return "SLL";
      op_slt: return "SLT";
      op_sltu: return "SLTU";
      op_xor: return "XOR";
      op_srl: return "SRL";
      op_sra: return "SRA";
      op_or: return "OR";
      default: return "AND";
    endcase
  endfunction

  function automatic logic [2:0] branch_f3(input int k);
    case (k)
      0: return 3'b000;
      1: return 3'b001;
      2: return 3'b100;
      3: return 3'b101;
      4: return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic string branch_name(input int k);
    case (k)
      0: return "BEQ";
      1: return "BNE";
      2: return "BLT";
      3: return "BGE";
      4: return "BLTU";
      default: return "BGEU";
    endcase
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit_word(input logic [31:0] word);
    imem[pc_w] = word;
    pc_w = pc_w + 1;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800; // ADDI sign-extends the low part
    emit_word(u_type(hi[31:12], rd, 7'b0110111));
    emit_word(i_type(v[11:0], rd, 3'd0, rd, opc_imm));
  endtask

  task automatic expect_store(input string name, input logic [31:0] adr, data);
    exp_name_q.push_back(name);
    exp_adr_q.push_back(adr);
    exp_dat_q.push_back(data);
  endtask

  task automatic alu_tests();
    logic [31:0] a, b, bval;
    logic [11:0] imm;
    int round, op;
    for (round = 0; round < 2; round++) begin
      for (op = 0; op < 10; op++) begin
        a = next_rand();
        b = next_rand();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit_word(r_type({1'b0, op_alt(op), 5'b0}, 5'd2, 5'd1, op_f3(op), 5'd3));
        emit_word(s_type(res_adr[11:0], 5'd3, 5'd0));
        expect_store(op_name(op), res_adr, ref_alu(op, a, b));
        if (op != op_sub) begin
          if (op_f3(op) == 3'd1 || op_f3(op) == 3'd5) begin
            imm = {1'b0, op_alt(op), 5'b0, b[4:0]}; // Shift amount form
            bval = {27'b0, b[4:0]};
          end else begin
            imm = b[11:0];
            bval = {{20{b[11]}}, b[11:0]};
          end
          emit_word(i_type(imm, 5'd1, op_f3(op), 5'd4, opc_imm));
          emit_word(s_type(res_adr[11:0], 5'd4, 5'd0));
          expect_store({op_name(op), " imm"}, res_adr, ref_alu(op, a, bval));
        end
      end
    end
  endtask

  task automatic branch_tests();
    logic [31:0] a, b;
    int round, k;
    for (round = 0; round < 2; round++) begin
      for (k = 0; k < 6; k++) begin
        a = next_rand();
        b = (round == 0) ? next_rand() : a;
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit_word(i_type(12'd0, 5'd0, 3'd0, 5'd6, opc_imm));
        emit_word(b_type(13'd8, 5'd2, 5'd1, branch_f3(k)));
        emit_word(i_type(12'd1, 5'd6, 3'd0, 5'd6, opc_imm)); // Skipped when taken
        emit_word(i_type(12'd2, 5'd6, 3'd0, 5'd6, opc_imm));
        emit_word(s_type(res_adr[11:0], 5'd6, 5'd0));
        expect_store(branch_name(k), res_adr, ref_branch(k, a, b) ? 32'd2 : 32'd3);
      end
    end
  endtask

  task automatic misc_tests();
    logic [31:0] r, link, c13, c14, c15, c16;
    r = next_rand();
    emit_word(u_type(r[19:0], 5'd4, 7'b0110111));
    emit_word(s_type(res_adr[11:0], 5'd4, 5'd0));
    expect_store("LUI", res_adr, {r[19:0], 12'b0});
    r = next_rand();
    link = pc_w * 4;
    emit_word(u_type(r[19:0], 5'd5, 7'b0010111));
    emit_word(s_type(res_adr[11:0], 5'd5, 5'd0));
    expect_store("AUIPC", res_adr, link + {r[19:0], 12'b0});

    link = pc_w * 4 + 4;
    emit_word(j_type(21'd8, 5'd7));
    emit_word(i_type(12'h123, 5'd0, 3'd0, 5'd7, opc_imm));
    emit_word(s_type(res_adr[11:0], 5'd7, 5'd0));
    expect_store("JAL", res_adr, link);
    link = (pc_w + 2) * 4 + 4;
    load_const(5'd10, (pc_w + 4) * 4 - 4); // JALR adds 4 back
    emit_word(i_type(12'd4, 5'd10, 3'd0, 5'd11, 7'b1100111));
    emit_word(i_type(12'h077, 5'd0, 3'd0, 5'd11, opc_imm));
    emit_word(s_type(res_adr[11:0], 5'd11, 5'd0));
    expect_store("JALR", res_adr, link);

    // Dependent chain, no gaps
    r = next_rand();
    c13 = ref_alu(op_add, r, r);
    c14 = ref_alu(op_xor, c13, r);
    c15 = ref_alu(op_sub, c14, c13);
    c16 = ref_alu(op_sll, c15, 32'd3);
    load_const(5'd12, r);
    emit_word(r_type(7'd0, 5'd12, 5'd12, 3'd0, 5'd13));
    emit_word(r_type(7'd0, 5'd12, 5'd13, 3'd4, 5'd14));
    emit_word(s_type(res_adr[11:0], 5'd14, 5'd0));
    emit_word(r_type(7'h20, 5'd13, 5'd14, 3'd0, 5'd15));
    emit_word(i_type(12'd3, 5'd15, 3'd1, 5'd16, opc_imm));
    emit_word(s_type(res_adr[11:0], 5'd16, 5'd0));
    expect_store("chain XOR", res_adr, c14);
    expect_store("chain SLLI", res_adr, c16);

    r = next_rand();
    load_const(5'd17, r);
    emit_word(32'h0000000f); // FENCE
    emit_word(32'h00000073); // ECALL
    emit_word(s_type(mem_adr[11:0], 5'd17, 5'd0));
    emit_word(i_type(mem_adr[11:0], 5'd0, 3'b010, 5'd18, 7'b0000011));
    emit_word(s_type(res_adr[11:0], 5'd18, 5'd0));
    expect_store("SW", mem_adr, r);
    expect_store("LW then SW", res_adr, r);
  endtask

  task automatic build_program();
    int a;
    for (a = 0; a < 256; a++) dmem[a] = 32'h9e3779b9 * (a + 1);
    pc_w = `RV_RESET_PC;
    alu_tests();
    branch_tests();
    misc_tests();
    emit_word(j_type(21'd0, 5'd0)); // Park here
    emit_word(i_type(12'd0, 5'd0, 3'd0, 5'd0, opc_imm));
    emit_word(i_type(12'd0, 5'd0, 3'd0, 5'd0, opc_imm));
  endtask

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] expected, actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic wait_for_fetch();
    int cycles;
    cycles = 0;
    while (wb_i_cyc_o !== 1'b1) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20) begin
        $display("Timed out waiting for the first instruction fetch after reset");
        stop_run();
      end
    end
  endtask

  task automatic wait_for_store(input string name);
    int cycles;
    cycles = 0;
    while (got_dat_q.size() == 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 2000) begin
        $display("Timed out waiting for the data store of test %s", name);
        stop_run();
      end
    end
  endtask

  // Both slaves in one process so the random stream has a fixed order
  always @(negedge clk_i) begin : bus_models
    wb_i_ack_i = 1'b0;
    wb_d_ack_i = 1'b0;
    if (wb_i_cyc_o && wb_i_stb_o) begin
      if (!i_busy) begin
        i_busy = 1'b1;
        i_wait = next_rand() % 4;
      end
      if (i_wait == 0) begin
        wb_i_ack_i = 1'b1;
        wb_i_data_i = imem[wb_i_adr_o[9:0]];
        i_busy = 1'b0;
      end else begin
        i_wait--;
      end
    end
    if (wb_d_cyc_o && wb_d_stb_o) begin
      if (!d_busy) begin
        d_busy = 1'b1;
        d_wait = next_rand() % 4;
      end
      if (d_wait == 0) begin
        wb_d_ack_i = 1'b1;
        d_busy = 1'b0;
        if (wb_d_we_o) begin
          dmem[wb_d_adr_o[7:0]] = wb_d_dat_o;
          got_adr_q.push_back({wb_d_adr_o, 2'b00});
          got_dat_q.push_back(wb_d_dat_o);
        end else begin
          wb_d_data_i = dmem[wb_d_adr_o[7:0]];
        end
      end else begin
        d_wait--;
      end
    end
  end

  initial begin : run_checks
    string name;
    logic [31:0] exp_adr, exp_dat;
    reset_ni = 1'b0;
    wb_i_ack_i = 1'b0;
    wb_i_data_i = '0;
    wb_d_ack_i = 1'b0;
    wb_d_data_i = '0;
    build_program();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_ni = 1'b1;
    wait_for_fetch();
    while (exp_name_q.size() > 0) begin
      name = exp_name_q.pop_front();
      exp_adr = exp_adr_q.pop_front();
      exp_dat = exp_dat_q.pop_front();
      wait_for_store(name);
      compare({name, " address"}, exp_adr, got_adr_q.pop_front());
      compare({name, " data"}, exp_dat, got_dat_q.pop_front());
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+src
src/rv_pkg.sv
src/rv_stage_if.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_lsu.sv
src/rv_core.sv
sim/rv_core_tb.sv

//--- src/rv_core.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_ni,
  input  logic                wb_i_ack_i,
  input  logic [`RV_XLEN-1:0] wb_i_data_i,
  output logic [`RV_AW-1:0]   wb_i_adr_o,
  output logic                wb_i_cyc_o,
  output logic                wb_i_stb_o,
  input  logic                wb_d_ack_i,
  input  logic [`RV_XLEN-1:0] wb_d_data_i,
  output logic [`RV_AW-1:0]   wb_d_adr_o,
  output logic [`RV_XLEN-1:0] wb_d_dat_o,
  output logic                wb_d_we_o,
  output logic                wb_d_cyc_o,
  output logic                wb_d_stb_o
);

  logic if_valid, if_ready;
  instr_u if_instr;
  logic [`RV_AW-1:0] if_pc;
  logic redirect;
  logic [`RV_AW-1:0] target;
  logic [$clog2(`RV_REGS)-1:0] rs1, rs2, rf_rd, ex_rd, ls_rd, wb_rd;
  logic [`RV_XLEN-1:0] rs1_data, rs2_data, rf_data;
  logic rf_we;

  id2ex_if id_ex_bus ();
  ex2ls_if ex_ls_bus ();

  rv_fetch fetch_inst (
    .clk_i, .reset_ni,
    .redirect_i(redirect), .target_i(target),
    .instr_ready_i(if_ready), .instr_valid_o(if_valid), .instr_o(if_instr), .pc_o(if_pc),
    .wb_ack_i(wb_i_ack_i), .wb_data_i(wb_i_data_i),
    .wb_adr_o(wb_i_adr_o), .wb_cyc_o(wb_i_cyc_o), .wb_stb_o(wb_i_stb_o)
  );

  rv_regfile regfile_inst (
    .clk_i,
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(rf_we), .rd_i(rf_rd), .rd_data_i(rf_data)
  );

  rv_decode decode_inst (
    .clk_i, .reset_ni, .flush_i(redirect),
    .valid_i(if_valid), .instr_i(if_instr), .pc_i(if_pc), .ready_o(if_ready),
    .rf_rs1_o(rs1), .rf_rs2_o(rs2), .rf_rs1_data_i(rs1_data), .rf_rs2_data_i(rs2_data),
    .ex_rd_i(ex_rd), .ls_rd_i(ls_rd), .wb_rd_i(wb_rd),
    .id_ex(id_ex_bus.source)
  );

  rv_execute execute_inst (
    .clk_i, .reset_ni,
    .id_ex(id_ex_bus.sink), .ex_ls(ex_ls_bus.source),
    .redirect_o(redirect), .target_o(target), .hz_rd_o(ex_rd)
  );

  rv_lsu lsu_inst (
    .clk_i, .reset_ni, .ex_ls(ex_ls_bus.sink),
    .wb_ack_i(wb_d_ack_i), .wb_data_i(wb_d_data_i), .wb_adr_o(wb_d_adr_o),
    .wb_dat_o(wb_d_dat_o), .wb_we_o(wb_d_we_o), .wb_cyc_o(wb_d_cyc_o), .wb_stb_o(wb_d_stb_o),
    .rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_data_o(rf_data), .hz_rd_o(ls_rd), .wb_rd_o(wb_rd)
  );

endmodule

//--- src/rv_decode.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_decode import rv_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_ni,
  input  logic                         flush_i,
  input  logic                         valid_i,
  input  instr_u                       instr_i,
  input  logic [`RV_AW-1:0]            pc_i,
  output logic                         ready_o,
  output logic [$clog2(`RV_REGS)-1:0]  rf_rs1_o,
  output logic [$clog2(`RV_REGS)-1:0]  rf_rs2_o,
  input  logic [`RV_XLEN-1:0]          rf_rs1_data_i,
  input  logic [`RV_XLEN-1:0]          rf_rs2_data_i,
  input  logic [$clog2(`RV_REGS)-1:0]  ex_rd_i,
  input  logic [$clog2(`RV_REGS)-1:0]  ls_rd_i,
  input  logic [$clog2(`RV_REGS)-1:0]  wb_rd_i,
  id2ex_if.source                      id_ex
);

  opcode_e opcode;
  logic [`RV_XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
  logic [`RV_XLEN-1:0] pc_byte;
  alu_cmd_e alu_f3, alu_cmd_d;
  branch_cmd_e br_f3, br_cmd_d;
  logic [`RV_XLEN-1:0] alu_lhs_d, alu_rhs_d, br_lhs_d, br_rhs_d;
  logic [$clog2(`RV_REGS)-1:0] rd_d;
  logic br_d, mem_en_d, mem_we_d;
  logic rs1_use, rs2_use;
  logic rs1_hit, rs2_hit;

  assign opcode = opcode_e'(instr_i.r.opcode);
  assign pc_byte = {pc_i, 2'b00};

  assign i_imm = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
  assign s_imm = {{20{instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rd};
  assign b_imm = {{20{instr_i.r.funct7[6]}}, instr_i.r.rd[0], instr_i.r.funct7[5:0],
                  instr_i.r.rd[4:1], 1'b0};
  assign u_imm = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'b0};
  assign j_imm = {{12{instr_i.r.funct7[6]}}, instr_i.r.rs1, instr_i.r.funct3,
                  instr_i.r.rs2[0], instr_i.r.funct7[5:0], instr_i.r.rs2[4:1], 1'b0};

  assign rf_rs1_o = instr_i.r.rs1;
  assign rf_rs2_o = instr_i.r.rs2;

  // Wait for older writers still in the pipe
  assign rs1_hit = rs1_use && instr_i.r.rs1 != '0 &&
    (instr_i.r.rs1 == ex_rd_i || instr_i.r.rs1 == ls_rd_i || instr_i.r.rs1 == wb_rd_i);
  assign rs2_hit = rs2_use && instr_i.r.rs2 != '0 &&
    (instr_i.r.rs2 == ex_rd_i || instr_i.r.rs2 == ls_rd_i || instr_i.r.rs2 == wb_rd_i);
  assign ready_o = !(valid_i && (rs1_hit || rs2_hit)) && (!id_ex.valid || id_ex.ready);

  always_comb begin
    unique case (instr_i.r.funct3)
      3'b000: alu_f3 = Add;
      3'b001: alu_f3 = Sll;
      3'b010: alu_f3 = Slt;
      3'b011: alu_f3 = Sltu;
      3'b100: alu_f3 = Xor;
      3'b101: alu_f3 = Srl;
      3'b110: alu_f3 = Or;
      default: alu_f3 = And;
    endcase

    unique case (instr_i.r.funct3)
      3'b001: br_f3 = Ne;
      3'b100: br_f3 = Lt;
      3'b101: br_f3 = Ge;
      3'b110: br_f3 = Ltu;
      3'b111: br_f3 = Geu;
      default: br_f3 = Eq;
    endcase
  end

  always_comb begin
    rd_d = instr_i.r.rd;
    rs1_use = 1'b1;
    rs2_use = 1'b0;
    alu_cmd_d = Add;
    alu_lhs_d = rf_rs1_data_i;
    alu_rhs_d = rf_rs2_data_i;
    br_d = 1'b0;
    br_cmd_d = Eq; // Zero operands make jumps always taken
    br_lhs_d = '0;
    br_rhs_d = '0;
    mem_en_d = 1'b0;
    mem_we_d = 1'b0;

    case (opcode)
      LUI: begin
        alu_lhs_d = u_imm;
        alu_rhs_d = '0;
        rs1_use = 1'b0;
      end
      AUIPC: begin
        alu_lhs_d = u_imm;
        alu_rhs_d = pc_byte;
        rs1_use = 1'b0;
      end
      OP_IMM: begin
        alu_cmd_d = alu_f3;
        if (instr_i.r.funct3 == 3'b101 && instr_i.r.funct7[5]) alu_cmd_d = Sra;
        alu_rhs_d = i_imm;
      end
      OP: begin
        alu_cmd_d = alu_f3;
        if (instr_i.r.funct7[5]) alu_cmd_d = (instr_i.r.funct3 == 3'b000) ? Sub : Sra;
        rs2_use = 1'b1;
      end
      JAL: begin
        br_d = 1'b1;
        alu_lhs_d = pc_byte;
        alu_rhs_d = j_imm;
        rs1_use = 1'b0;
      end
      JALR: begin
        br_d = 1'b1;
        alu_rhs_d = i_imm; // Target from rs1
      end
      BRANCH: begin
        br_d = 1'b1;
        br_cmd_d = br_f3;
        br_lhs_d = rf_rs1_data_i;
        br_rhs_d = rf_rs2_data_i;
        alu_lhs_d = pc_byte;
        alu_rhs_d = b_imm;
        rd_d = '0;
        rs2_use = 1'b1;
      end
      LOAD: begin
        mem_en_d = 1'b1;
        alu_rhs_d = i_imm;
      end
      STORE: begin
        mem_en_d = 1'b1;
        mem_we_d = 1'b1;
        alu_rhs_d = s_imm;
        rd_d = '0;
        rs2_use = 1'b1;
      end
      default: begin // FENCE, SYSTEM and unknown retire as no-ops
        rd_d = '0;
        rs1_use = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni || flush_i) id_ex.valid <= 1'b0;
    else if (ready_o) id_ex.valid <= valid_i;
    else if (id_ex.ready) id_ex.valid <= 1'b0; // Consumed while stalled
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      id_ex.pc <= pc_i;
      id_ex.rd <= rd_d;
      id_ex.alu_cmd <= alu_cmd_d;
      id_ex.alu_lhs <= alu_lhs_d;
      id_ex.alu_rhs <= alu_rhs_d;
      id_ex.is_branch <= br_d;
      id_ex.br_cmd <= br_cmd_d;
      id_ex.br_lhs <= br_lhs_d;
      id_ex.br_rhs <= br_rhs_d;
      id_ex.mem_en <= mem_en_d;
      id_ex.mem_we <= mem_we_d;
      id_ex.store_data <= rf_rs2_data_i;
    end
  end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_execute import rv_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_ni,
  id2ex_if.sink                        id_ex,
  ex2ls_if.source                      ex_ls,
  output logic                         redirect_o,
  output logic [`RV_AW-1:0]            target_o,
  output logic [$clog2(`RV_REGS)-1:0]  hz_rd_o
);

  logic [$clog2(`RV_XLEN)-1:0] shamt;
  logic [`RV_XLEN-1:0] alu_res;
  logic taken;
  logic accept;
  logic redirect_q;
  logic [`RV_AW-1:0] target_q;

  assign shamt = id_ex.alu_rhs[$clog2(`RV_XLEN)-1:0];
  assign id_ex.ready = !ex_ls.valid || ex_ls.ready;
  assign accept = id_ex.valid && id_ex.ready && !redirect_q; // Input is wrong path during redirect
  assign hz_rd_o = id_ex.valid ? id_ex.rd : '0;
  assign redirect_o = redirect_q;
  assign target_o = target_q;

  always_comb begin
    unique case (id_ex.alu_cmd)
      Sub:  alu_res = id_ex.alu_lhs - id_ex.alu_rhs;
      Sll:  alu_res = id_ex.alu_lhs << shamt;
      Slt:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(id_ex.alu_lhs) < $signed(id_ex.alu_rhs)};
      Sltu: alu_res = {{(`RV_XLEN-1){1'b0}}, id_ex.alu_lhs < id_ex.alu_rhs};
      Xor:  alu_res = id_ex.alu_lhs ^ id_ex.alu_rhs;
      Srl:  alu_res = id_ex.alu_lhs >> shamt;
      Sra:  alu_res = $signed(id_ex.alu_lhs) >>> shamt;
      Or:   alu_res = id_ex.alu_lhs | id_ex.alu_rhs;
      And:  alu_res = id_ex.alu_lhs & id_ex.alu_rhs;
      default: alu_res = id_ex.alu_lhs + id_ex.alu_rhs;
    endcase

    unique case (id_ex.br_cmd)
      Ne:  taken = id_ex.br_lhs != id_ex.br_rhs;
      Lt:  taken = $signed(id_ex.br_lhs) < $signed(id_ex.br_rhs);
      Ge:  taken = $signed(id_ex.br_lhs) >= $signed(id_ex.br_rhs);
      Ltu: taken = id_ex.br_lhs < id_ex.br_rhs;
      Geu: taken = id_ex.br_lhs >= id_ex.br_rhs;
      default: taken = id_ex.br_lhs == id_ex.br_rhs;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      ex_ls.valid <= 1'b0;
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= accept && id_ex.is_branch && taken;
      if (id_ex.ready) ex_ls.valid <= id_ex.valid && !redirect_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_ex.ready) begin
      ex_ls.rd <= id_ex.rd;
      ex_ls.result <= id_ex.is_branch ? {id_ex.pc, 2'b00} + `RV_XLEN'(4) : alu_res; // Link
      ex_ls.mem_en <= id_ex.mem_en;
      ex_ls.mem_we <= id_ex.mem_we;
      ex_ls.store_data <= id_ex.store_data;
      target_q <= alu_res[`RV_XLEN-1:2];
    end
  end

endmodule

//--- src/rv_fetch.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_fetch import rv_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_ni,
  input  logic               redirect_i,
  input  logic [`RV_AW-1:0]  target_i,
  input  logic               instr_ready_i,
  output logic               instr_valid_o,
  output instr_u             instr_o,
  output logic [`RV_AW-1:0]  pc_o,
  input  logic               wb_ack_i,
  input  logic [`RV_XLEN-1:0] wb_data_i,
  output logic [`RV_AW-1:0]  wb_adr_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o
);

  logic [`RV_AW-1:0] pc_q;
  logic [`RV_AW-1:0] adr_q;
  logic cyc_q;
  logic valid_q;
  logic drop_q; // Ack of a fetch made stale by a redirect
  instr_u instr_q;
  logic [`RV_AW-1:0] instr_pc_q;

  assign wb_adr_o = adr_q;
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign instr_valid_o = valid_q;
  assign instr_o = instr_q;
  assign pc_o = instr_pc_q;

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      cyc_q <= 1'b0;
      valid_q <= 1'b0;
      drop_q <= 1'b0;
      pc_q <= `RV_RESET_PC;
    end else begin
      if (cyc_q && wb_ack_i) cyc_q <= 1'b0;
      else if (!cyc_q && !valid_q && !redirect_i) cyc_q <= 1'b1;

      if (cyc_q && wb_ack_i) drop_q <= 1'b0;
      else if (cyc_q && redirect_i) drop_q <= 1'b1;

      if (redirect_i) valid_q <= 1'b0;
      else if (cyc_q && wb_ack_i && !drop_q) valid_q <= 1'b1;
      else if (instr_ready_i) valid_q <= 1'b0;

      if (redirect_i) pc_q <= target_i;
      else if (valid_q && instr_ready_i) pc_q <= pc_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!cyc_q) adr_q <= pc_q; // Held stable while the request is open
    if (cyc_q && wb_ack_i) begin
      instr_q <= wb_data_i;
      instr_pc_q <= adr_q;
    end
  end

endmodule

//--- src/rv_lsu.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_lsu (
  input  logic                         clk_i,
  input  logic                         reset_ni,
  ex2ls_if.sink                        ex_ls,
  input  logic                         wb_ack_i,
  input  logic [`RV_XLEN-1:0]          wb_data_i,
  output logic [`RV_AW-1:0]            wb_adr_o,
  output logic [`RV_XLEN-1:0]          wb_dat_o,
  output logic                         wb_we_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         rf_we_o,
  output logic [$clog2(`RV_REGS)-1:0]  rf_rd_o,
  output logic [`RV_XLEN-1:0]          rf_data_o,
  output logic [$clog2(`RV_REGS)-1:0]  hz_rd_o,
  output logic [$clog2(`RV_REGS)-1:0]  wb_rd_o
);

  logic take;
  logic cyc_q;
  logic valid_q;
  logic we_q;
  logic [$clog2(`RV_REGS)-1:0] rd_q;
  logic [`RV_XLEN-1:0] data_q; // Address until the load data replaces it
  logic [`RV_XLEN-1:0] dat_q;

  assign ex_ls.ready = !cyc_q;
  assign take = ex_ls.valid && !cyc_q;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o = we_q;
  assign wb_adr_o = data_q[`RV_XLEN-1:2];
  assign wb_dat_o = dat_q;

  assign rf_we_o = valid_q && rd_q != '0;
  assign rf_rd_o = rd_q;
  assign rf_data_o = data_q;

  assign hz_rd_o = ex_ls.valid ? ex_ls.rd : '0;
  // A load in flight also blocks its readers
  assign wb_rd_o = (valid_q || cyc_q) ? rd_q : '0;

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      cyc_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= (take && !ex_ls.mem_en) || (cyc_q && wb_ack_i);
      if (take && ex_ls.mem_en) cyc_q <= 1'b1;
      else if (wb_ack_i) cyc_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      rd_q <= ex_ls.rd;
      data_q <= ex_ls.result;
      dat_q <= ex_ls.store_data;
      we_q <= ex_ls.mem_we;
    end else if (cyc_q && wb_ack_i && !we_q) begin
      data_q <= wb_data_i;
    end
  end

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

  typedef enum logic [6:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111,
    SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    Add, Sub, Sll, Slt, Sltu, Xor, Srl, Sra, Or, And
  } alu_cmd_e;

  typedef enum logic [2:0] {
    Eq, Ne, Lt, Ge, Ltu, Geu
  } branch_cmd_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // Same word, register view or immediate view
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

endpackage

//--- src/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_regfile (
  input  logic                         clk_i,
  input  logic [$clog2(`RV_REGS)-1:0]  rs1_i,
  input  logic [$clog2(`RV_REGS)-1:0]  rs2_i,
  output logic [`RV_XLEN-1:0]          rs1_data_o,
  output logic [`RV_XLEN-1:0]          rs2_data_o,
  input  logic                         we_i,
  input  logic [$clog2(`RV_REGS)-1:0]  rd_i,
  input  logic [`RV_XLEN-1:0]          rd_data_i
);

  logic [`RV_XLEN-1:0] regs [1:`RV_REGS-1]; // No storage for x0

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk_i) begin
    if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule

//--- src/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REGS 32

// Word address width of the pc and both bus ports
`define RV_AW 30

// First word fetched after reset
`define RV_RESET_PC 30'd0

`endif

//--- src/rv_stage_if.sv
`timescale 1ns/100ps
`include "rv_settings.svh"

interface id2ex_if import rv_pkg::*; ();
  logic                         valid;
  logic                         ready;
  logic [`RV_AW-1:0]            pc;
  logic [$clog2(`RV_REGS)-1:0]  rd;
  alu_cmd_e                     alu_cmd;
  logic [`RV_XLEN-1:0]          alu_lhs;
  logic [`RV_XLEN-1:0]          alu_rhs;
  logic                         is_branch; // Branch or jump
  branch_cmd_e                  br_cmd;
  logic [`RV_XLEN-1:0]          br_lhs;
  logic [`RV_XLEN-1:0]          br_rhs;
  logic                         mem_en;
  logic                         mem_we;
  logic [`RV_XLEN-1:0]          store_data;

  modport source (
    output valid, pc, rd, alu_cmd, alu_lhs, alu_rhs, is_branch, br_cmd, br_lhs, br_rhs,
           mem_en, mem_we, store_data,
    input  ready
  );

  modport sink (
    input  valid, pc, rd, alu_cmd, alu_lhs, alu_rhs, is_branch, br_cmd, br_lhs, br_rhs,
           mem_en, mem_we, store_data,
    output ready
  );
endinterface

interface ex2ls_if ();
  logic                         valid;
  logic                         ready;
  logic [$clog2(`RV_REGS)-1:0]  rd;
  logic [`RV_XLEN-1:0]          result; // Also the memory address
  logic                         mem_en;
  logic                         mem_we;
  logic [`RV_XLEN-1:0]          store_data;

  modport source (output valid, rd, result, mem_en, mem_we, store_data, input ready);
  modport sink (input valid, rd, result, mem_en, mem_we, store_data, output ready);
endinterface
